/* design/secv_pkg.sv */
// Data width, instruction union, opcode and selector enums, decode stage structs
`default_nettype none

package secv_pkg;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned REG_ADR_W = 5;     // 32 integer registers

    // Field types
    typedef logic [2:0]           funct3_t;
    typedef logic [6:0]           funct7_t;
    typedef logic [REG_ADR_W-1:0] regadr_t;

    // Base opcodes plus the tag memory opcode in custom-0
    typedef enum logic [6:0] {
        OPCODE_LUI       = 7'b0110111,
        OPCODE_AUIPC     = 7'b0010111,
        OPCODE_JAL       = 7'b1101111,
        OPCODE_JALR      = 7'b1100111,
        OPCODE_BRANCH    = 7'b1100011,
        OPCODE_LOAD      = 7'b0000011,
        OPCODE_STORE     = 7'b0100011,
        OPCODE_CUSTOM_0  = 7'b0001011,     // Tag memory access
        OPCODE_OP        = 7'b0110011,
        OPCODE_OP_32     = 7'b0111011,
        OPCODE_OP_IMM    = 7'b0010011,
        OPCODE_OP_IMM_32 = 7'b0011011
    } opcode_t;

    // Instruction format views, MSB first
    typedef struct packed {
        funct7_t     funct7;
        regadr_t     rs2;
        regadr_t     rs1;
        funct3_t     funct3;
        regadr_t     rd;
        logic [6:0]  opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        regadr_t     rs1;
        funct3_t     funct3;
        regadr_t     rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]  imm_11_5;
        regadr_t     rs2;
        regadr_t     rs1;
        funct3_t     funct3;
        logic [4:0]  imm_4_0;
        logic [6:0]  opcode;
    } s_type_t;

    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        regadr_t     rs2;
        regadr_t     rs1;
        funct3_t     funct3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        logic [6:0]  opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        regadr_t     rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        regadr_t     rd;
        logic [6:0]  opcode;
    } j_type_t;

    // One instruction word, six ways to read it
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        s_type_t s_type;
        b_type_t b_type;
        u_type_t u_type;
        j_type_t j_type;
    } inst_t;

    // Selectors
    typedef enum logic [1:0] {FUNIT_NONE, FUNIT_ALU, FUNIT_MEM, FUNIT_MTAG} funit_t;
    typedef enum logic {ALU_OP_SEL_DECODER, ALU_OP_SEL_ADD} alu_op_sel_t;
    typedef enum logic [1:0] {SRC1_SEL_0, SRC1_SEL_PC, SRC1_SEL_RS1, SRC1_SEL_RS1_IMM} src1_sel_t;
    typedef enum logic [1:0] {SRC2_SEL_0, SRC2_SEL_RS2, SRC2_SEL_IMM} src2_sel_t;
    typedef enum logic [2:0] {
        IMM_SEL_0, IMM_SEL_I, IMM_SEL_S, IMM_SEL_B, IMM_SEL_U, IMM_SEL_J
    } imm_sel_t;
    typedef enum logic [1:0] {RD_SEL_NONE, RD_SEL_IMM, RD_SEL_FUNIT, RD_SEL_NXTPC} rd_sel_t;
    typedef enum logic [1:0] {PC_SEL_NXTPC, PC_SEL_FUNIT, PC_SEL_BRANCH} pc_sel_t;

    // All immediate formats, built in parallel
    typedef struct packed {
        logic [XLEN-1:0] i;
        logic [XLEN-1:0] s;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] u;
        logic [XLEN-1:0] j;
    } imm_set_t;

    // Control handed on to execute and write-back
    typedef struct packed {
        opcode_t     opcode;
        funct3_t     funct3;
        funct7_t     funct7;
        regadr_t     rd_adr;
        funit_t      funit;
        alu_op_sel_t alu_op_sel;
        rd_sel_t     rd_sel;
        pc_sel_t     pc_sel;
    } decode_ctrl_t;

    // Registered stage result
    typedef struct packed {
        decode_ctrl_t    ctrl;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
        logic            err;
    } decode_out_t;

endpackage

`default_nettype wire

/* design/decoder.sv */
// Control decoder from opcode to function unit, operand, immediate and PC selections
`default_nettype none

module decoder (
    input  secv_pkg::inst_t        inst_i,      // Fetched instruction

    output secv_pkg::decode_ctrl_t ctrl_o,      // Control for execute and write-back
    output secv_pkg::src1_sel_t    src1_sel_o,  // Source 1 selection
    output secv_pkg::src2_sel_t    src2_sel_o,  // Source 2 selection
    output secv_pkg::imm_sel_t     imm_sel_o,   // Immediate format
    output logic                   err_o        // Invalid opcode
);

    secv_pkg::opcode_t     opcode;
    secv_pkg::funit_t      funit;
    secv_pkg::alu_op_sel_t alu_op_sel;
    secv_pkg::src1_sel_t   src1_sel;
    secv_pkg::src2_sel_t   src2_sel;
    secv_pkg::imm_sel_t    imm_sel;
    secv_pkg::rd_sel_t     rd_sel;
    secv_pkg::pc_sel_t     pc_sel;
    logic                  err;

    // Opcode sits at the same place in every format
    assign opcode = secv_pkg::opcode_t'(inst_i.r_type.opcode);

    always_comb begin : decode_op
        funit      = secv_pkg::FUNIT_NONE;
        alu_op_sel = secv_pkg::ALU_OP_SEL_DECODER;
        src1_sel   = secv_pkg::SRC1_SEL_0;
        src2_sel   = secv_pkg::SRC2_SEL_0;
        imm_sel    = secv_pkg::IMM_SEL_0;
        rd_sel     = secv_pkg::RD_SEL_NONE;
        pc_sel     = secv_pkg::PC_SEL_NXTPC;
        err        = 1'b0;

        unique case (opcode)
            secv_pkg::OPCODE_LUI: begin
                imm_sel = secv_pkg::IMM_SEL_U;
                rd_sel  = secv_pkg::RD_SEL_IMM;    // Immediate straight to rd
            end

            secv_pkg::OPCODE_AUIPC: begin
                funit      = secv_pkg::FUNIT_ALU;
                alu_op_sel = secv_pkg::ALU_OP_SEL_ADD;
                src1_sel   = secv_pkg::SRC1_SEL_PC;
                src2_sel   = secv_pkg::SRC2_SEL_IMM;
                imm_sel    = secv_pkg::IMM_SEL_U;
                rd_sel     = secv_pkg::RD_SEL_FUNIT;
            end

            secv_pkg::OPCODE_JAL: begin
                funit      = secv_pkg::FUNIT_ALU;
                alu_op_sel = secv_pkg::ALU_OP_SEL_ADD;    // Jump target
                src1_sel   = secv_pkg::SRC1_SEL_PC;
                src2_sel   = secv_pkg::SRC2_SEL_IMM;
                imm_sel    = secv_pkg::IMM_SEL_J;
                rd_sel     = secv_pkg::RD_SEL_NXTPC;    // Link address
                pc_sel     = secv_pkg::PC_SEL_FUNIT;
            end

            secv_pkg::OPCODE_JALR: begin
                funit      = secv_pkg::FUNIT_ALU;
                alu_op_sel = secv_pkg::ALU_OP_SEL_ADD;
                src1_sel   = secv_pkg::SRC1_SEL_RS1;
                src2_sel   = secv_pkg::SRC2_SEL_IMM;
                imm_sel    = secv_pkg::IMM_SEL_I;
                rd_sel     = secv_pkg::RD_SEL_NXTPC;
                pc_sel     = secv_pkg::PC_SEL_FUNIT;
            end

            secv_pkg::OPCODE_BRANCH: begin
                // ALU forms the target, the condition is resolved later
                funit      = secv_pkg::FUNIT_ALU;
                alu_op_sel = secv_pkg::ALU_OP_SEL_ADD;
                src1_sel   = secv_pkg::SRC1_SEL_PC;
                src2_sel   = secv_pkg::SRC2_SEL_IMM;
                imm_sel    = secv_pkg::IMM_SEL_B;
                pc_sel     = secv_pkg::PC_SEL_BRANCH;
            end

            secv_pkg::OPCODE_LOAD: begin
                funit    = secv_pkg::FUNIT_MEM;
                src1_sel = secv_pkg::SRC1_SEL_RS1_IMM;    // Effective address
                src2_sel = secv_pkg::SRC2_SEL_0;
                imm_sel  = secv_pkg::IMM_SEL_I;
                rd_sel   = secv_pkg::RD_SEL_FUNIT;
            end

            secv_pkg::OPCODE_STORE: begin
                funit    = secv_pkg::FUNIT_MEM;
                src1_sel = secv_pkg::SRC1_SEL_RS1_IMM;    // Effective address
                src2_sel = secv_pkg::SRC2_SEL_RS2;        // Store data
                imm_sel  = secv_pkg::IMM_SEL_S;
            end

            secv_pkg::OPCODE_CUSTOM_0: begin
                // Tag memory access, no destination register
                funit    = secv_pkg::FUNIT_MTAG;
                src1_sel = secv_pkg::SRC1_SEL_RS1;
                src2_sel = secv_pkg::SRC2_SEL_RS2;
            end

            // Word forms behave as the plain forms for XLEN 32
            secv_pkg::OPCODE_OP, secv_pkg::OPCODE_OP_32: begin
                funit    = secv_pkg::FUNIT_ALU;
                src1_sel = secv_pkg::SRC1_SEL_RS1;
                src2_sel = secv_pkg::SRC2_SEL_RS2;
                rd_sel   = secv_pkg::RD_SEL_FUNIT;
            end

            secv_pkg::OPCODE_OP_IMM, secv_pkg::OPCODE_OP_IMM_32: begin
                funit    = secv_pkg::FUNIT_ALU;
                src1_sel = secv_pkg::SRC1_SEL_RS1;
                src2_sel = secv_pkg::SRC2_SEL_IMM;
                imm_sel  = secv_pkg::IMM_SEL_I;
                rd_sel   = secv_pkg::RD_SEL_FUNIT;
            end

            default: begin
                err = 1'b1;    // Unknown opcode
            end
        endcase
    end

    // Control bundle
    always_comb begin : ctrl_pack
        ctrl_o.opcode     = opcode;
        ctrl_o.funct3     = inst_i.r_type.funct3;
        ctrl_o.funct7     = inst_i.r_type.funct7;
        ctrl_o.rd_adr     = inst_i.r_type.rd;
        ctrl_o.funit      = funit;
        ctrl_o.alu_op_sel = alu_op_sel;
        ctrl_o.rd_sel     = rd_sel;
        ctrl_o.pc_sel     = pc_sel;
    end

    assign src1_sel_o = src1_sel;
    assign src2_sel_o = src2_sel;
    assign imm_sel_o  = imm_sel;
    assign err_o      = err;

endmodule

`default_nettype wire

/* design/imm_gen.sv */
// Immediate generator for the sign-extended I, S, B, U and J formats
`default_nettype none

module imm_gen (
    input  secv_pkg::inst_t    inst_i,      // Fetched instruction
    output secv_pkg::imm_set_t imm_set_o    // One immediate per format
);

    // Sign bit is always inst[31]
    logic sign;

    assign sign = inst_i.r_type.funct7[6];

    // Loads, ALU immediates and JALR
    assign imm_set_o.i = {{(secv_pkg::XLEN-12){sign}}, inst_i.i_type.imm_11_0};

    // Stores
    assign imm_set_o.s = {{(secv_pkg::XLEN-12){sign}},
                          inst_i.s_type.imm_11_5,
                          inst_i.s_type.imm_4_0};

    // Halfword aligned branch offset
    assign imm_set_o.b = {{(secv_pkg::XLEN-12){inst_i.b_type.imm_12}},
                          inst_i.b_type.imm_11,
                          inst_i.b_type.imm_10_5,
                          inst_i.b_type.imm_4_1,
                          1'b0};

    // Upper immediate
    assign imm_set_o.u = {inst_i.u_type.imm_31_12, 12'b0};

    // Halfword aligned jump offset
    assign imm_set_o.j = {{(secv_pkg::XLEN-20){inst_i.j_type.imm_20}},
                          inst_i.j_type.imm_19_12,
                          inst_i.j_type.imm_11,
                          inst_i.j_type.imm_10_1,
                          1'b0};

endmodule

`default_nettype wire

/* design/operand_select.sv */
// Immediate selection, source operand forming and the decode output register
`default_nettype none

module operand_select (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         valid_i,       // Instruction strobe

    // From decoder
    input  secv_pkg::decode_ctrl_t       ctrl_i,
    input  secv_pkg::src1_sel_t          src1_sel_i,
    input  secv_pkg::src2_sel_t          src2_sel_i,
    input  secv_pkg::imm_sel_t           imm_sel_i,
    input  logic                         err_i,

    // From immediate generator
    input  secv_pkg::imm_set_t           imm_set_i,

    // Operand sources
    input  logic [secv_pkg::XLEN-1:0]    pc_i,
    input  logic [secv_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [secv_pkg::XLEN-1:0]    rs2_data_i,

    output logic                         valid_o,
    output secv_pkg::decode_out_t        out_o
);

    logic [secv_pkg::XLEN-1:0] imm;
    logic [secv_pkg::XLEN-1:0] src1;
    logic [secv_pkg::XLEN-1:0] src2;
    secv_pkg::decode_out_t     out_d;
    secv_pkg::decode_out_t     out_q;
    logic                      valid_q;

    // Immediate format
    always_comb begin : imm_mux
        unique case (imm_sel_i)
            secv_pkg::IMM_SEL_I: imm = imm_set_i.i;
            secv_pkg::IMM_SEL_S: imm = imm_set_i.s;
            secv_pkg::IMM_SEL_B: imm = imm_set_i.b;
            secv_pkg::IMM_SEL_U: imm = imm_set_i.u;
            secv_pkg::IMM_SEL_J: imm = imm_set_i.j;
            default:             imm = '0;    // No immediate
        endcase
    end

    // Source 1
    always_comb begin : src1_mux
        unique case (src1_sel_i)
            secv_pkg::SRC1_SEL_PC:      src1 = pc_i;
            secv_pkg::SRC1_SEL_RS1:     src1 = rs1_data_i;
            secv_pkg::SRC1_SEL_RS1_IMM: src1 = rs1_data_i + imm;    // Load and store address
            default:                    src1 = '0;
        endcase
    end

    // Source 2
    always_comb begin : src2_mux
        unique case (src2_sel_i)
            secv_pkg::SRC2_SEL_RS2: src2 = rs2_data_i;
            secv_pkg::SRC2_SEL_IMM: src2 = imm;
            default:                src2 = '0;
        endcase
    end

    always_comb begin : out_pack
        out_d.ctrl = ctrl_i;
        out_d.imm  = imm;
        out_d.src1 = src1;
        out_d.src2 = src2;
        out_d.err  = err_i;
    end

    // Result holds while no new instruction arrives
    always_ff @(posedge clk_i or negedge arst_n_i) begin : out_reg
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            out_q   <= '0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                out_q <= out_d;
            end
        end
    end

    assign valid_o = valid_q;
    assign out_o   = out_q;

endmodule

`default_nettype wire

/* design/decode_stage.sv */
// Decode stage top level with decoder, immediate generator and operand selector
`default_nettype none

module decode_stage (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      valid_i,      // Instruction strobe
    input  secv_pkg::inst_t           inst_i,
    input  logic [secv_pkg::XLEN-1:0] pc_i,
    input  logic [secv_pkg::XLEN-1:0] rs1_data_i,   // Register file read data
    input  logic [secv_pkg::XLEN-1:0] rs2_data_i,

    output secv_pkg::regadr_t         rs1_adr_o,    // Register file read addresses
    output secv_pkg::regadr_t         rs2_adr_o,
    output logic                      valid_o,
    output secv_pkg::decode_out_t     out_o
);

    secv_pkg::decode_ctrl_t ctrl;
    secv_pkg::src1_sel_t    src1_sel;
    secv_pkg::src2_sel_t    src2_sel;
    secv_pkg::imm_sel_t     imm_sel;
    logic                   err;
    secv_pkg::imm_set_t     imm_set;

    assign rs1_adr_o = inst_i.r_type.rs1;
    assign rs2_adr_o = inst_i.r_type.rs2;

    decoder decoder_i (
        .inst_i     (inst_i),
        .ctrl_o     (ctrl),
        .src1_sel_o (src1_sel),
        .src2_sel_o (src2_sel),
        .imm_sel_o  (imm_sel),
        .err_o      (err)
    );

    imm_gen imm_gen_i (
        .inst_i    (inst_i),
        .imm_set_o (imm_set)
    );

    operand_select operand_select_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .valid_i    (valid_i),
        .ctrl_i     (ctrl),
        .src1_sel_i (src1_sel),
        .src2_sel_i (src2_sel),
        .imm_sel_i  (imm_sel),
        .err_i      (err),
        .imm_set_i  (imm_set),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .valid_o    (valid_o),
        .out_o      (out_o)
    );

endmodule

`default_nettype wire

/* tb/decode_stage_asserts.sv */
// Concurrent assertions on valid timing and decode consistency, with their bind
`default_nettype none

module decode_stage_asserts (
    input logic                   clk_i,
    input logic                   arst_n_i,
    input logic                   strobe_in_i,    // Instruction strobe into the stage
    input logic                   strobe_out_i,   // Result strobe out of the stage
    input secv_pkg::decode_out_t  result_i,
    input secv_pkg::funit_t       funit_i,        // Decoder output, before the register
    input secv_pkg::src1_sel_t    src1_sel_i
);

    int unsigned fail_count = 0;    // Polled by the testbench

    a_reset_no_valid: assert property (@(posedge clk_i) !arst_n_i |-> !strobe_out_i)
        else begin
            $error("valid_o high while reset is asserted");
            fail_count++;
        end

    a_valid_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        strobe_in_i |=> strobe_out_i)
        else begin
            $error("valid_o missing one cycle after valid_i");
            fail_count++;
        end

    a_valid_fall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !strobe_in_i |=> !strobe_out_i)
        else begin
            $error("valid_o high without valid_i one cycle earlier");
            fail_count++;
        end

    // Invalid opcodes keep the default unit
    a_err_no_funit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        result_i.err |-> result_i.ctrl.funit == secv_pkg::FUNIT_NONE)
        else begin
            $error("err set with a function unit selected");
            fail_count++;
        end

    a_mem_address: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        funit_i == secv_pkg::FUNIT_MEM |-> src1_sel_i == secv_pkg::SRC1_SEL_RS1_IMM)
        else begin
            $error("memory access without rs1 plus immediate as source 1");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_asserts asserts_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .strobe_in_i  (valid_i),
    .strobe_out_i (valid_o),
    .result_i     (out_o),
    .funit_i      (ctrl.funit),
    .src1_sel_i   (src1_sel)
);

`default_nettype wire

/* tb/decode_stage_tb.sv */
// Testbench for the decode stage with random instructions, reference model and watchdog
`default_nettype none

module decode_stage_tb;

    localparam int unsigned PERIOD       = 8;
    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned NUM_INST     = 2000;
    // Idle cycles are one in eight on average, so twice the count leaves room
    localparam int unsigned TIMEOUT      = (2 * NUM_INST + RESET_CYCLES + 20) * PERIOD;

    logic                      clk;
    logic                      arst_n;
    logic                      valid_in;
    secv_pkg::inst_t           inst;
    logic [secv_pkg::XLEN-1:0] pc;
    logic [secv_pkg::XLEN-1:0] rs1_data;
    logic [secv_pkg::XLEN-1:0] rs2_data;
    secv_pkg::regadr_t         rs1_adr;
    secv_pkg::regadr_t         rs2_adr;
    logic                      valid_out;
    secv_pkg::decode_out_t     out;

    integer                    seed;
    logic [31:0]               regfile [32];      // Register file model
    logic [31:0]               cur_word;          // Word currently on inst
    logic                      exp_valid;
    secv_pkg::decode_out_t     exp_q [$];         // One-deep expected results
    secv_pkg::decode_out_t     last_out;          // Value out should hold

    secv_pkg::opcode_t legal_ops [12] = '{
        secv_pkg::OPCODE_LUI, secv_pkg::OPCODE_AUIPC, secv_pkg::OPCODE_JAL,
        secv_pkg::OPCODE_JALR, secv_pkg::OPCODE_BRANCH, secv_pkg::OPCODE_LOAD,
        secv_pkg::OPCODE_STORE, secv_pkg::OPCODE_CUSTOM_0, secv_pkg::OPCODE_OP,
        secv_pkg::OPCODE_OP_32, secv_pkg::OPCODE_OP_IMM, secv_pkg::OPCODE_OP_IMM_32
    };

    assign rs1_data = regfile[rs1_adr];
    assign rs2_data = regfile[rs2_adr];

    decode_stage dut_i (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .valid_i    (valid_in),
        .inst_i     (inst),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_adr_o  (rs1_adr),
        .rs2_adr_o  (rs2_adr),
        .valid_o    (valid_out),
        .out_o      (out)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic stop_failed();
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
            stop_failed();
        end
    endtask

    // Reference decode straight from the instruction bits
    function automatic secv_pkg::decode_out_t expected_out(input logic [31:0] w,
        input logic [31:0] pc_v, input logic [31:0] r1, input logic [31:0] r2);
        logic [31:0]           imm_i;
        logic [31:0]           imm_s;
        logic [31:0]           imm_b;
        logic [31:0]           imm_u;
        logic [31:0]           imm_j;
        secv_pkg::decode_out_t e;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e = '0;
        e.ctrl.opcode = secv_pkg::opcode_t'(w[6:0]);
        e.ctrl.funct3 = w[14:12];
        e.ctrl.funct7 = w[31:25];
        e.ctrl.rd_adr = w[11:7];
        case (w[6:0])
            secv_pkg::OPCODE_LUI: begin
                e.imm         = imm_u;
                e.ctrl.rd_sel = secv_pkg::RD_SEL_IMM;
            end
            secv_pkg::OPCODE_AUIPC, secv_pkg::OPCODE_JAL, secv_pkg::OPCODE_BRANCH: begin
                e.ctrl.funit      = secv_pkg::FUNIT_ALU;
                e.ctrl.alu_op_sel = secv_pkg::ALU_OP_SEL_ADD;
                e.imm  = (w[6:0] == secv_pkg::OPCODE_AUIPC) ? imm_u :
                         (w[6:0] == secv_pkg::OPCODE_JAL)   ? imm_j : imm_b;
                e.src1 = pc_v;     // PC plus immediate
                e.src2 = e.imm;
                if (w[6:0] == secv_pkg::OPCODE_AUIPC) begin
                    e.ctrl.rd_sel = secv_pkg::RD_SEL_FUNIT;
                end else if (w[6:0] == secv_pkg::OPCODE_JAL) begin
                    e.ctrl.rd_sel = secv_pkg::RD_SEL_NXTPC;
                    e.ctrl.pc_sel = secv_pkg::PC_SEL_FUNIT;
                end else begin
                    e.ctrl.pc_sel = secv_pkg::PC_SEL_BRANCH;
                end
            end
            secv_pkg::OPCODE_JALR: begin
                e.ctrl.funit      = secv_pkg::FUNIT_ALU;
                e.ctrl.alu_op_sel = secv_pkg::ALU_OP_SEL_ADD;
                e.ctrl.rd_sel     = secv_pkg::RD_SEL_NXTPC;
                e.ctrl.pc_sel     = secv_pkg::PC_SEL_FUNIT;
                e.imm  = imm_i;
                e.src1 = r1;
                e.src2 = imm_i;
            end
            secv_pkg::OPCODE_LOAD: begin
                e.ctrl.funit  = secv_pkg::FUNIT_MEM;
                e.ctrl.rd_sel = secv_pkg::RD_SEL_FUNIT;
                e.imm  = imm_i;
                e.src1 = r1 + imm_i;
            end
            secv_pkg::OPCODE_STORE: begin
                e.ctrl.funit = secv_pkg::FUNIT_MEM;
                e.imm  = imm_s;
                e.src1 = r1 + imm_s;
                e.src2 = r2;    // Store data
            end
            secv_pkg::OPCODE_CUSTOM_0: begin
                e.ctrl.funit = secv_pkg::FUNIT_MTAG;
                e.src1 = r1;
                e.src2 = r2;
            end
            secv_pkg::OPCODE_OP, secv_pkg::OPCODE_OP_32: begin
                e.ctrl.funit  = secv_pkg::FUNIT_ALU;
                e.ctrl.rd_sel = secv_pkg::RD_SEL_FUNIT;
                e.src1 = r1;
                e.src2 = r2;
            end
            secv_pkg::OPCODE_OP_IMM, secv_pkg::OPCODE_OP_IMM_32: begin
                e.ctrl.funit  = secv_pkg::FUNIT_ALU;
                e.ctrl.rd_sel = secv_pkg::RD_SEL_FUNIT;
                e.imm  = imm_i;
                e.src1 = r1;
                e.src2 = imm_i;
            end
            default: e.err = 1'b1;
        endcase
        return e;
    endfunction

    task automatic check_out(input secv_pkg::decode_out_t exp);
        compare_value("out_o.ctrl.opcode", out.ctrl.opcode, exp.ctrl.opcode);
        compare_value("out_o.ctrl.funct3", out.ctrl.funct3, exp.ctrl.funct3);
        compare_value("out_o.ctrl.funct7", out.ctrl.funct7, exp.ctrl.funct7);
        compare_value("out_o.ctrl.rd_adr", out.ctrl.rd_adr, exp.ctrl.rd_adr);
        compare_value("out_o.ctrl.funit", out.ctrl.funit, exp.ctrl.funit);
        compare_value("out_o.ctrl.alu_op_sel", out.ctrl.alu_op_sel, exp.ctrl.alu_op_sel);
        compare_value("out_o.ctrl.rd_sel", out.ctrl.rd_sel, exp.ctrl.rd_sel);
        compare_value("out_o.ctrl.pc_sel", out.ctrl.pc_sel, exp.ctrl.pc_sel);
        compare_value("out_o.imm", out.imm, exp.imm);
        compare_value("out_o.src1", out.src1, exp.src1);
        compare_value("out_o.src2", out.src2, exp.src2);
        compare_value("out_o.err", out.err, exp.err);
    endtask

    // Sample just after the edge and before new inputs go on
    task automatic check_cycle();
        @(posedge clk);
        #1;
        if (exp_q.size() != 0) begin
            last_out = exp_q.pop_front();
        end
        compare_value("valid_o", valid_out, exp_valid);
        check_out(last_out);
        compare_value("rs1_adr_o", rs1_adr, cur_word[19:15]);
        compare_value("rs2_adr_o", rs2_adr, cur_word[24:20]);
    endtask

    task automatic drive_inst(input logic issue);
        logic [31:0] word;
        logic [6:0]  opc;
        if (($random(seed) & 3) != 0) begin
            opc = legal_ops[$unsigned($random(seed)) % 12];
        end else begin
            opc = 7'($random(seed));    // Mostly illegal opcodes
        end
        word      = $random(seed);
        word[6:0] = opc;
        cur_word  = word;
        inst      = word;
        pc        = $random(seed);
        pc[1:0]   = 2'b00;
        valid_in  = issue;
        exp_valid = issue;
        if (issue) begin
            exp_q.push_back(expected_out(word, pc, regfile[word[19:15]], regfile[word[24:20]]));
        end
    endtask

    initial begin : stimulus
        int unsigned issued;
        logic        issue;
        seed      = 32'h47c5b862;
        clk       = 1'b0;
        arst_n    = 1'b0;
        valid_in  = 1'b0;
        inst      = '0;
        pc        = '0;
        cur_word  = '0;
        exp_valid = 1'b0;
        last_out  = '0;
        issued    = 0;
        for (int i = 0; i < 32; i++) begin
            regfile[i] = $random(seed);
        end
        regfile[0] = '0;    // x0 reads zero

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            compare_value("valid_o", valid_out, 1'b0);
            check_out('0);
        end
        arst_n = 1'b1;
        check_cycle();    // First cycle out of reset

        while (issued < NUM_INST) begin
            issue = (($random(seed) & 7) != 0);
            drive_inst(issue);
            if (issue) begin
                issued++;
            end
            check_cycle();
        end
        drive_inst(1'b0);
        check_cycle();    // valid_o drops and out_o holds

        if (dut_i.asserts_i.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("A concurrent assertion on the decode stage failed at %0t", $time);
            stop_failed();
        end
    end

    // Sticky count in the bound assertion checker
    always @(posedge clk) begin : assertion_watch
        if (dut_i.asserts_i.fail_count != 0) begin
            $display("A concurrent assertion on the decode stage failed at %0t", $time);
            stop_failed();
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        stop_failed();
    end

endmodule

`default_nettype wire

/* sim.f */
design/secv_pkg.sv
design/decoder.sv
design/imm_gen.sv
design/operand_select.sv
design/decode_stage.sv
tb/decode_stage_asserts.sv
tb/decode_stage_tb.sv
